/* list.f */
+incdir+include
rtl/cam_pkg.sv
rtl/pixel_reconstruct.sv
rtl/rgb_to_ycrcb.sv
rtl/ycc_threshold.sv
rtl/video_mux.sv
rtl/pixel_stacker.sv
rtl/camera_pipeline_top.sv
testbench/tb_camera_checks.sv
testbench/tb_camera_pipeline.sv

/* testbench/tb_camera_pipeline.sv */
`include "cam_consts.svh"

module tb_camera_pipeline;
  import cam_pkg::*;

  localparam int FRAME_W          = 16;
  localparam int FRAME_H          = 4;
  localparam int CLK_PERIOD       = 8;
  localparam int RESET_CYCLES     = 4;
  localparam int HALF_CYC         = 4;  // clk_camera cycles per pclk half period
  localparam int IDLE_MAX         = 3;  // extra low half periods before a byte
  localparam int HGAP_BYTES       = 3;  // junk bytes while hsync is low
  localparam int VGAP_BYTES       = 4;  // junk bytes while vsync is low
  localparam int NUM_FRAMES       = 4;
  localparam int TAIL_CYCLES      = 64;
  localparam int CHUNKS_PER_FRAME = FRAME_W * FRAME_H / `CAM_PIX_PER_CHUNK;
  // worst case half periods of one frame, idle included
  localparam int HALVES_PER_FRAME =
    FRAME_H * (FRAME_W * 2 * (2 + IDLE_MAX) + HGAP_BYTES * 2) + VGAP_BYTES * 2;
  localparam int TIMEOUT =
    (NUM_FRAMES * HALVES_PER_FRAME * HALF_CYC + 1000) * CLK_PERIOD;
  localparam logic [31:0] SEED = 32'he382_0c13;

  logic                   clk_camera;
  logic                   recent_reset;
  logic                   cam_pclk;
  logic                   cam_hsync;
  logic                   cam_vsync;
  logic [`CAM_DATA_W-1:0] cam_data;
  cutoff_t                cutoff;
  display_mode_t          display_mode;
  logic                   chunk_valid;
  chunk_t                 chunk_data;
  logic                   chunk_last;
  logic [31:0]            rng;
  int                     errors;

  always #(CLK_PERIOD / 2) clk_camera = ~clk_camera;

  camera_pipeline_top #(.FRAME_W(FRAME_W), .FRAME_H(FRAME_H)) u_camera_pipeline_top (
    .clk_camera    (clk_camera),
    .recent_reset  (recent_reset),
    .cam_pclk_i    (cam_pclk),
    .cam_hsync_i   (cam_hsync),
    .cam_vsync_i   (cam_vsync),
    .cam_data_i    (cam_data),
    .cutoff_i      (cutoff),
    .display_mode_i(display_mode),
    .chunk_valid_o (chunk_valid),
    .chunk_data_o  (chunk_data),
    .chunk_last_o  (chunk_last)
  );

  tb_camera_checks #(.FRAME_W(FRAME_W), .FRAME_H(FRAME_H)) u_camera_checks (
    .clk_camera    (clk_camera),
    .recent_reset  (recent_reset),
    .display_mode_i(display_mode),
    .cutoff_i      (cutoff),
    .chunk_valid_i (chunk_valid),
    .chunk_data_i  (chunk_data),
    .chunk_last_i  (chunk_last)
  );

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // inputs always move 1 unit after a rising edge
  task automatic step(input int n);
    repeat (n) @(posedge clk_camera);
    #1;
  endtask

  // data and syncs change with the pclk fall, the rise comes a half period later
  task automatic send_byte(input logic [7:0] b, input logic hs, input logic vs, input int idle);
    cam_pclk  = 1'b0;
    cam_data  = b;
    cam_hsync = hs;
    cam_vsync = vs;
    step(HALF_CYC * (1 + idle));  // idle stretches the low phase
    cam_pclk = 1'b1;
    step(HALF_CYC);
  endtask

  task automatic send_frame(input logic use_idle);
    logic [15:0] pix;
    int          idle;
    int          line;
    int          col;
    int          k;
    for (k = 0; k < VGAP_BYTES; k++) begin
      rng = lcg_step(rng);
      send_byte(rng[31:24], 1'b1, 1'b0, 0);  // hsync up, frame not started
    end
    for (line = 0; line < FRAME_H; line++) begin
      for (col = 0; col < FRAME_W; col++) begin
        rng  = lcg_step(rng);
        pix  = rng[31:16];
        idle = use_idle ? int'(rng[15:14]) : 0;
        send_byte(pix[15:8], 1'b1, 1'b1, idle);
        u_camera_checks.push_pixel(pix, (col == FRAME_W - 1) && (line == FRAME_H - 1));
        send_byte(pix[7:0], 1'b1, 1'b1, 0);
      end
      for (k = 0; k < HGAP_BYTES; k++) begin
        rng = lcg_step(rng);
        send_byte(rng[31:24], 1'b0, 1'b1, 0);  // ignored, line blanking
      end
    end
  endtask

  task automatic pick_cutoffs();
    rng       = lcg_step(rng);
    cutoff.y  = {1'b0, rng[31:25]};
    cutoff.cr = 8'd96 + rng[24:20];  // around mid scale so some pixels pass
    cutoff.cb = 8'd96 + rng[19:15];
  endtask

  task automatic wait_drain();
    while (u_camera_checks.pending != 0) begin
      step(1);
    end
  endtask

  initial begin
    clk_camera   = 1'b0;
    recent_reset = 1'b1;
    cam_pclk     = 1'b0;
    cam_hsync    = 1'b0;
    cam_vsync    = 1'b0;
    cam_data     = '0;
    cutoff       = '0;
    display_mode = `CAM_MODE_CAMERA;
    rng          = SEED;
    errors       = 0;
    repeat (RESET_CYCLES) @(posedge clk_camera);
    #1;
    recent_reset = 1'b0;

    // camera mode, steady pclk
    send_frame(1'b0);
    wait_drain();
    // mask and overlay with random bounds, pclk stalls now and then
    display_mode = `CAM_MODE_MASK;
    pick_cutoffs();
    send_frame(1'b1);
    wait_drain();
    display_mode = `CAM_MODE_OVERLAY;
    pick_cutoffs();
    send_frame(1'b1);
    wait_drain();
    display_mode = 2'b01;  // spare code shows the camera
    send_frame(1'b1);
    wait_drain();
    step(TAIL_CYCLES);  // any stray chunk lands on the checks here

    u_camera_checks.check_total(NUM_FRAMES * CHUNKS_PER_FRAME);
    errors = u_camera_checks.data_errors + u_camera_checks.last_errors
           + u_camera_checks.count_errors + u_camera_checks.protocol_errors;
    $display("chunks %0d, data errors %0d, last flag errors %0d, count errors %0d, %s %0d",
             u_camera_checks.chunk_total, u_camera_checks.data_errors,
             u_camera_checks.last_errors, u_camera_checks.count_errors,
             "protocol errors", u_camera_checks.protocol_errors);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  // watchdog
  initial begin
    #(TIMEOUT);
    $display("Timeout: the frames were not all returned within %0d time units", TIMEOUT);
    $display("Simulation failed");
    $finish;
  end

endmodule

/* testbench/tb_camera_checks.sv */
`include "cam_consts.svh"

module tb_camera_checks #(
  parameter int FRAME_W = `CAM_FRAME_W,
  parameter int FRAME_H = `CAM_FRAME_H
) (
  input logic                   clk_camera,
  input logic                   recent_reset,
  input cam_pkg::display_mode_t display_mode_i,
  input cam_pkg::cutoff_t       cutoff_i,
  input logic                   chunk_valid_i,
  input cam_pkg::chunk_t        chunk_data_i,
  input logic                   chunk_last_i
);
  import cam_pkg::*;

  localparam int PPC              = `CAM_PIX_PER_CHUNK;
  localparam int CHUNKS_PER_FRAME = FRAME_W * FRAME_H / PPC;

  typedef struct packed {
    logic    frame_end;  // pixel sits at the frame's last column and row
    rgb565_t pix;        // display value after conversion, threshold and mux
  } exp_pix_t;

  exp_pix_t exp_q[$];               // sent pixels not yet seen in a chunk
  chunk_t   exp_chunk = '0;         // next eight queued values, pixel 0 low
  logic     exp_last = 1'b0;
  logic     exp_avail = 1'b0;       // eight or more pixels queued
  int       pending = 0;
  int       frame_chunks = 0;       // chunks since the last flagged one
  int       chunk_total = 0;
  int       data_errors = 0;
  int       last_errors = 0;
  int       count_errors = 0;
  int       protocol_errors = 0;

  function automatic logic [7:0] clamp_byte(input int v);
    if (v < 0) begin
      return 8'd0;
    end else if (v > 255) begin
      return 8'd255;
    end
    return v[7:0];
  endfunction

  // bt.601 in integer math, channels widened by a plain left shift
  function automatic ycc_t model_ycc(input rgb565_t p);
    int   r;
    int   g;
    int   b;
    ycc_t v;
    r    = int'(p.r) * 8;
    g    = int'(p.g) * 4;
    b    = int'(p.b) * 8;
    v.y  = clamp_byte(((66 * r + 129 * g + 25 * b + 128) >>> 8) + 16);
    v.cb = clamp_byte(((-38 * r - 74 * g + 112 * b + 128) >>> 8) + 128);
    v.cr = clamp_byte(((112 * r - 94 * g - 18 * b + 128) >>> 8) + 128);
    return v;
  endfunction

  function automatic rgb565_t model_display(input rgb565_t p, input display_mode_t mode,
                                            input cutoff_t c);
    ycc_t v;
    logic hit;
    v   = model_ycc(p);
    hit = (v.y >= c.y) && (v.cr >= c.cr) && (v.cb >= c.cb);  // bounds are inclusive
    case (mode)
      `CAM_MODE_MASK:    return hit ? `CAM_MASK_ON : `CAM_MASK_OFF;
      `CAM_MODE_OVERLAY: return hit ? `CAM_OVERLAY_COLOR : p;
      default:           return p;  // 00 and 01 both show the camera
    endcase
  endfunction

  task automatic refresh_expected();
    chunk_t c;
    logic   l;
    int     i;
    c = '0;
    l = 1'b0;
    if (exp_q.size() >= PPC) begin
      for (i = 0; i < PPC; i++) begin
        c[i*`CAM_PIXEL_W +: `CAM_PIXEL_W] = exp_q[i].pix;
      end
      l = exp_q[PPC-1].frame_end;  // eighth pixel decides the flag
    end
    exp_chunk = c;
    exp_last  = l;
    exp_avail = (exp_q.size() >= PPC);
    pending   = exp_q.size();
  endtask

  // called by the stimulus once per pixel, under the mode and cutoffs in force
  task automatic push_pixel(input rgb565_t raw, input logic frame_end);
    exp_pix_t e;
    e.pix       = model_display(raw, display_mode_i, cutoff_i);
    e.frame_end = frame_end;
    exp_q.push_back(e);
    refresh_expected();
  endtask

  task automatic consume_chunk(input logic last);
    int i;
    for (i = 0; i < PPC; i++) begin
      if (exp_q.size() > 0) begin
        void'(exp_q.pop_front());
      end
    end
    chunk_total  = chunk_total + 1;
    frame_chunks = last ? 0 : frame_chunks + 1;
    refresh_expected();
  endtask

  // old chunk values are read here, the assertions sampled them already
  always @(posedge clk_camera) begin
    if (!recent_reset && chunk_valid_i) begin
      consume_chunk(chunk_last_i);
    end
  end

  task automatic check_total(input int expected);
    a_chunk_total : assert (chunk_total == expected)
      else begin
        count_errors = count_errors + 1;
        $display("Error at time %0t: chunk count expected %0d got %0d",
                 $time, expected, chunk_total);
      end
  endtask

  a_reset_quiet : assert property (@(posedge clk_camera)
    recent_reset |=> (!chunk_valid_i && !chunk_last_i))
    else begin
      protocol_errors = protocol_errors + 1;
      $display("at time %0t reset left chunk_valid_o or chunk_last_o high", $time);
    end

  a_chunk_expected : assert property (@(posedge clk_camera) disable iff (recent_reset)
    chunk_valid_i |-> exp_avail)
    else begin
      protocol_errors = protocol_errors + 1;
      $display("at time %0t a chunk came out before eight pixels were sent", $time);
    end

  a_chunk_data : assert property (@(posedge clk_camera) disable iff (recent_reset)
    (chunk_valid_i && exp_avail) |-> (chunk_data_i == exp_chunk))
    else begin
      data_errors = data_errors + 1;
      $display("Error at time %0t: chunk_data_o expected %h got %h",
               $time, $sampled(exp_chunk), $sampled(chunk_data_i));
    end

  // flag only on the chunk holding the frame's final pixel
  a_chunk_last : assert property (@(posedge clk_camera) disable iff (recent_reset)
    (chunk_valid_i || chunk_last_i) |-> (chunk_last_i == (chunk_valid_i && exp_last)))
    else begin
      last_errors = last_errors + 1;
      $display("Error at time %0t: chunk_last_o expected %b got %b",
               $time, $sampled(chunk_valid_i && exp_last), $sampled(chunk_last_i));
    end

  a_frame_size : assert property (@(posedge clk_camera) disable iff (recent_reset)
    chunk_valid_i |-> (frame_chunks < CHUNKS_PER_FRAME))
    else begin
      count_errors = count_errors + 1;
      $display("at time %0t a frame ran past %0d chunks", $time, CHUNKS_PER_FRAME);
    end

  a_frame_end : assert property (@(posedge clk_camera) disable iff (recent_reset)
    (chunk_valid_i && chunk_last_i) |-> (frame_chunks == CHUNKS_PER_FRAME - 1))
    else begin
      count_errors = count_errors + 1;
      $display("Error at time %0t: chunk index at frame end expected %0d got %0d",
               $time, CHUNKS_PER_FRAME - 1, $sampled(frame_chunks));
    end

endmodule

/* rtl/camera_pipeline_top.sv */
`include "cam_consts.svh"

module camera_pipeline_top #(
  parameter int FRAME_W = `CAM_FRAME_W,
  parameter int FRAME_H = `CAM_FRAME_H
) (
  input  logic                   clk_camera,
  input  logic                   recent_reset,
  input  logic                   cam_pclk_i,   // camera bus is async to clk_camera
  input  logic                   cam_hsync_i,
  input  logic                   cam_vsync_i,
  input  logic [`CAM_DATA_W-1:0] cam_data_i,
  input  cam_pkg::cutoff_t       cutoff_i,     // static levels
  input  cam_pkg::display_mode_t display_mode_i,
  output logic                   chunk_valid_o,
  output cam_pkg::chunk_t        chunk_data_o,
  output logic                   chunk_last_o
);
  import cam_pkg::*;

  pixel_rec_t recon_rec;
  ycc_t       conv_ycc;
  pixel_rec_t conv_rec;
  logic       mask;
  pixel_rec_t mask_rec;
  pixel_rec_t disp_rec;

  // input side
  pixel_reconstruct #(.FRAME_W(FRAME_W), .FRAME_H(FRAME_H)) u_pixel_reconstruct (
    .clk_camera  (clk_camera),
    .recent_reset(recent_reset),
    .cam_pclk_i  (cam_pclk_i),
    .cam_hsync_i (cam_hsync_i),
    .cam_vsync_i (cam_vsync_i),
    .cam_data_i  (cam_data_i),
    .pix_rec_o   (recon_rec)
  );

  rgb_to_ycrcb u_rgb_to_ycrcb (  // 3 cycles
    .clk_camera  (clk_camera),
    .recent_reset(recent_reset),
    .pix_rec_i   (recon_rec),
    .ycc_o       (conv_ycc),
    .pix_rec_o   (conv_rec)
  );

  ycc_threshold u_ycc_threshold (
    .clk_camera  (clk_camera),
    .recent_reset(recent_reset),
    .ycc_i       (conv_ycc),
    .pix_rec_i   (conv_rec),
    .cutoff_i    (cutoff_i),
    .mask_o      (mask),
    .pix_rec_o   (mask_rec)
  );

  video_mux u_video_mux (
    .clk_camera    (clk_camera),
    .recent_reset  (recent_reset),
    .display_mode_i(display_mode_i),
    .mask_i        (mask),
    .pix_rec_i     (mask_rec),
    .pix_rec_o     (disp_rec)
  );

  // output side, consumer takes every chunk
  pixel_stacker #(.FRAME_W(FRAME_W), .FRAME_H(FRAME_H)) u_pixel_stacker (
    .clk_camera   (clk_camera),
    .recent_reset (recent_reset),
    .pix_rec_i    (disp_rec),
    .chunk_valid_o(chunk_valid_o),
    .chunk_data_o (chunk_data_o),
    .chunk_last_o (chunk_last_o)
  );

endmodule

/* rtl/pixel_stacker.sv */
`include "cam_consts.svh"

module pixel_stacker #(
  parameter int FRAME_W = `CAM_FRAME_W,
  parameter int FRAME_H = `CAM_FRAME_H
) (
  input  logic                clk_camera,
  input  logic                recent_reset,
  input  cam_pkg::pixel_rec_t pix_rec_i,
  output logic                chunk_valid_o,
  output cam_pkg::chunk_t     chunk_data_o,
  output logic                chunk_last_o
);
  import cam_pkg::*;

  localparam int FILL_W = $clog2(`CAM_PIX_PER_CHUNK);
  localparam logic [FILL_W-1:0] FILL_LAST = FILL_W'(`CAM_PIX_PER_CHUNK - 1);

  logic [FILL_W-1:0] fill_q;     // pixels already in the chunk
  chunk_t            chunk_q;
  logic              frame_end;  // incoming pixel is the frame's last

  assign frame_end = (pix_rec_i.hcount == FRAME_W - 1) && (pix_rec_i.vcount == FRAME_H - 1);

  // newest pixel enters at the top so pixel 0 ends up in the low bits
  always_ff @(posedge clk_camera) begin
    if (pix_rec_i.valid) begin
      chunk_q <= {pix_rec_i.pix, chunk_q[`CAM_CHUNK_W-1:`CAM_PIXEL_W]};
    end
  end

  always_ff @(posedge clk_camera) begin
    if (recent_reset) begin
      fill_q        <= '0;
      chunk_valid_o <= 1'b0;
      chunk_last_o  <= 1'b0;
    end else begin
      chunk_valid_o <= 1'b0;
      chunk_last_o  <= 1'b0;
      if (pix_rec_i.valid) begin
        if (fill_q == FILL_LAST) begin
          fill_q        <= '0;
          chunk_valid_o <= 1'b1;
          chunk_last_o  <= frame_end;
        end else begin
          fill_q <= fill_q + 1'b1;
        end
      end
    end
  end

  assign chunk_data_o = chunk_q;

  // chunks never straddle a line end
  if (FRAME_W % `CAM_PIX_PER_CHUNK != 0) begin : g_bad_frame_w
    $error("pixel_stacker: FRAME_W %0d not a multiple of %0d", FRAME_W, `CAM_PIX_PER_CHUNK);
  end

  a_last_needs_valid : assert property (@(posedge clk_camera) disable iff (recent_reset)
    chunk_last_o |-> chunk_valid_o)
    else $error("pixel_stacker: chunk_last_o without chunk_valid_o");

  // upstream counts and the fill count agree at the frame end
  a_frame_end_aligned : assert property (@(posedge clk_camera) disable iff (recent_reset)
    (pix_rec_i.valid && frame_end) |-> (fill_q == FILL_LAST))
    else $error("pixel_stacker: frame ended with %0d pixels in the chunk", fill_q);

endmodule

/* rtl/video_mux.sv */
`include "cam_consts.svh"

module video_mux (
  input  logic                   clk_camera,
  input  logic                   recent_reset,
  input  cam_pkg::display_mode_t display_mode_i,
  input  logic                   mask_i,
  input  cam_pkg::pixel_rec_t    pix_rec_i,
  output cam_pkg::pixel_rec_t    pix_rec_o
);
  import cam_pkg::*;

  rgb565_t    pix_sel;
  pixel_rec_t rec_q;

  always_comb begin
    case (display_mode_i)
      `CAM_MODE_CAMERA: begin
        pix_sel = pix_rec_i.pix;
      end
      `CAM_MODE_MASK: begin
        pix_sel = mask_i ? `CAM_MASK_ON : `CAM_MASK_OFF;  // full white or black
      end
      `CAM_MODE_OVERLAY: begin
        pix_sel = mask_i ? `CAM_OVERLAY_COLOR : pix_rec_i.pix;  // magenta over hits
      end
      default: begin
        pix_sel = pix_rec_i.pix;  // code 01 shows the camera too
      end
    endcase
  end

  // counts and valid ride along untouched
  always_ff @(posedge clk_camera) begin
    rec_q     <= pix_rec_i;
    rec_q.pix <= pix_sel;
    if (recent_reset) begin
      rec_q.valid <= 1'b0;
    end
  end

  assign pix_rec_o = rec_q;

endmodule

/* rtl/ycc_threshold.sv */
`include "cam_consts.svh"

module ycc_threshold (
  input  logic                clk_camera,
  input  logic                recent_reset,
  input  cam_pkg::ycc_t       ycc_i,
  input  cam_pkg::pixel_rec_t pix_rec_i,
  input  cam_pkg::cutoff_t    cutoff_i,
  output logic                mask_o,
  output cam_pkg::pixel_rec_t pix_rec_o
);
  import cam_pkg::*;

  logic       y_ok;
  logic       cr_ok;
  logic       cb_ok;
  logic       pass;
  pixel_rec_t rec_q;

  // inclusive lower bounds on every channel
  assign y_ok  = (ycc_i.y >= cutoff_i.y);
  assign cr_ok = (ycc_i.cr >= cutoff_i.cr);
  assign cb_ok = (ycc_i.cb >= cutoff_i.cb);
  assign pass  = y_ok && cr_ok && cb_ok && pix_rec_i.valid;  // no mask on idle cycles

  always_ff @(posedge clk_camera) begin
    rec_q <= pix_rec_i;
    if (recent_reset) begin
      rec_q.valid <= 1'b0;
      mask_o      <= 1'b0;
    end else begin
      mask_o <= pass;
    end
  end

  assign pix_rec_o = rec_q;

endmodule

/* rtl/rgb_to_ycrcb.sv */
`include "cam_consts.svh"

module rgb_to_ycrcb (
  input  logic                clk_camera,
  input  logic                recent_reset,
  input  cam_pkg::pixel_rec_t pix_rec_i,
  output cam_pkg::ycc_t       ycc_o,
  output cam_pkg::pixel_rec_t pix_rec_o
);
  import cam_pkg::*;

  logic [7:0]         r8;
  logic [7:0]         g8;
  logic [7:0]         b8;
  logic [15:0]        y_prod  [3];  // index 0 r, 1 g, 2 b
  logic [15:0]        cb_prod [3];
  logic [15:0]        cr_prod [3];
  logic signed [18:0] y_sum;
  logic signed [18:0] cb_sum;
  logic signed [18:0] cr_sum;
  pixel_rec_t         rec_pipe [3];

  // zero extend a product into the signed sum width
  function automatic logic signed [18:0] ext(input logic [15:0] p);
    return $signed({3'b000, p});
  endfunction

  // drop the rounding bits, add the offset and saturate to a byte
  function automatic logic [7:0] clamp8(input logic signed [18:0] s,
                                        input logic signed [18:0] offset);
    logic signed [18:0] v;
    v = (s >>> 8) + offset;
    if (v < 0) begin
      return 8'd0;
    end else if (v > 255) begin
      return 8'd255;
    end
    return v[7:0];
  endfunction

  // widen 565 to 888 by shifting left
  assign r8 = {pix_rec_i.pix.r, 3'b000};
  assign g8 = {pix_rec_i.pix.g, 2'b00};
  assign b8 = {pix_rec_i.pix.b, 3'b000};

  always_ff @(posedge clk_camera) begin
    // stage 1 products
    y_prod[0]  <= 16'(`CAM_Y_R * r8);
    y_prod[1]  <= 16'(`CAM_Y_G * g8);
    y_prod[2]  <= 16'(`CAM_Y_B * b8);
    cb_prod[0] <= 16'(`CAM_CB_R * r8);
    cb_prod[1] <= 16'(`CAM_CB_G * g8);
    cb_prod[2] <= 16'(`CAM_CB_B * b8);
    cr_prod[0] <= 16'(`CAM_CR_R * r8);
    cr_prod[1] <= 16'(`CAM_CR_G * g8);
    cr_prod[2] <= 16'(`CAM_CR_B * b8);
    // stage 2 sums with the rounding constant
    y_sum  <= ext(y_prod[0]) + ext(y_prod[1]) + ext(y_prod[2]) + 19'sd128;
    cb_sum <= ext(cb_prod[2]) - ext(cb_prod[0]) - ext(cb_prod[1]) + 19'sd128;
    cr_sum <= ext(cr_prod[0]) - ext(cr_prod[1]) - ext(cr_prod[2]) + 19'sd128;
    // stage 3 shift offset clamp
    ycc_o.y  <= clamp8(y_sum, 19'sd16);
    ycc_o.cb <= clamp8(cb_sum, 19'sd128);
    ycc_o.cr <= clamp8(cr_sum, 19'sd128);
  end

  // record follows the math three stages deep
  always_ff @(posedge clk_camera) begin
    rec_pipe[0] <= pix_rec_i;
    rec_pipe[1] <= rec_pipe[0];
    rec_pipe[2] <= rec_pipe[1];
    if (recent_reset) begin
      rec_pipe[0].valid <= 1'b0;
      rec_pipe[1].valid <= 1'b0;
      rec_pipe[2].valid <= 1'b0;
    end
  end

  assign pix_rec_o = rec_pipe[2];

endmodule

/* rtl/pixel_reconstruct.sv */
`include "cam_consts.svh"

module pixel_reconstruct #(
  parameter int FRAME_W = `CAM_FRAME_W,
  parameter int FRAME_H = `CAM_FRAME_H
) (
  input  logic                   clk_camera,
  input  logic                   recent_reset,
  input  logic                   cam_pclk_i,
  input  logic                   cam_hsync_i,
  input  logic                   cam_vsync_i,
  input  logic [`CAM_DATA_W-1:0] cam_data_i,
  output cam_pkg::pixel_rec_t    pix_rec_o
);
  import cam_pkg::*;

  logic [1:0]               pclk_sync;   // bit 1 is the settled copy
  logic [1:0]               hsync_sync;
  logic [1:0]               vsync_sync;
  logic [`CAM_DATA_W-1:0]   data_meta;
  logic [`CAM_DATA_W-1:0]   data_sync;

  logic                     pclk_prev;
  logic                     hsync_prev;
  logic                     vsync_prev;
  logic                     pclk_rise_q;
  logic                     hsync_fall_q;
  logic                     vsync_fall_q;
  logic                     active_q;    // inside a line and a frame
  logic [`CAM_DATA_W-1:0]   data_q;

  logic                     byte_phase;  // 1 once the high byte is held
  logic [`CAM_DATA_W-1:0]   high_byte;
  logic [`CAM_HCOUNT_W-1:0] hcount_q;
  logic [`CAM_VCOUNT_W-1:0] vcount_q;
  pixel_rec_t               rec_q;

  // double flop the control lines
  always_ff @(posedge clk_camera) begin
    if (recent_reset) begin
      pclk_sync  <= '0;
      hsync_sync <= '0;
      vsync_sync <= '0;
    end else begin
      pclk_sync  <= {pclk_sync[0], cam_pclk_i};
      hsync_sync <= {hsync_sync[0], cam_hsync_i};
      vsync_sync <= {vsync_sync[0], cam_vsync_i};
    end
  end

  always_ff @(posedge clk_camera) begin
    data_meta <= cam_data_i;
    data_sync <= data_meta;
    data_q    <= data_sync;   // lines up with the edge flags
  end

  // edge detect stage on the synchronized copies
  always_ff @(posedge clk_camera) begin
    if (recent_reset) begin
      pclk_prev    <= 1'b0;
      hsync_prev   <= 1'b0;
      vsync_prev   <= 1'b0;
      pclk_rise_q  <= 1'b0;
      hsync_fall_q <= 1'b0;
      vsync_fall_q <= 1'b0;
      active_q     <= 1'b0;
    end else begin
      pclk_prev    <= pclk_sync[1];
      hsync_prev   <= hsync_sync[1];
      vsync_prev   <= vsync_sync[1];
      pclk_rise_q  <= pclk_sync[1] & ~pclk_prev;
      hsync_fall_q <= hsync_prev & ~hsync_sync[1];
      vsync_fall_q <= vsync_prev & ~vsync_sync[1];
      active_q     <= hsync_sync[1] & vsync_sync[1];
    end
  end

  // byte pairing and counting
  always_ff @(posedge clk_camera) begin
    if (recent_reset) begin
      byte_phase  <= 1'b0;
      hcount_q    <= '0;
      vcount_q    <= '0;
      rec_q.valid <= 1'b0;
    end else begin
      rec_q.valid <= 1'b0;
      if (vsync_fall_q) begin           // new frame
        vcount_q   <= '0;
        hcount_q   <= '0;
        byte_phase <= 1'b0;
      end else if (hsync_fall_q) begin  // end of line
        hcount_q <= '0;
        vcount_q <= vcount_q + 1'b1;
      end else if (pclk_rise_q && active_q) begin
        if (!byte_phase) begin
          high_byte  <= data_q;
          byte_phase <= 1'b1;
        end else begin
          rec_q.pix    <= {high_byte, data_q};  // high byte first on the bus
          rec_q.hcount <= hcount_q;
          rec_q.vcount <= vcount_q;
          rec_q.valid  <= 1'b1;
          hcount_q     <= hcount_q + 1'b1;
          byte_phase   <= 1'b0;
        end
      end
    end
  end

  assign pix_rec_o = rec_q;

  // counts must stay inside the configured frame
  a_hcount_in_frame : assert property (@(posedge clk_camera) disable iff (recent_reset)
    rec_q.valid |-> (rec_q.hcount < FRAME_W))
    else $error("pixel_reconstruct: hcount %0d beyond frame width", rec_q.hcount);

  a_vcount_in_frame : assert property (@(posedge clk_camera) disable iff (recent_reset)
    rec_q.valid |-> (rec_q.vcount < FRAME_H))
    else $error("pixel_reconstruct: vcount %0d beyond frame height", rec_q.vcount);

endmodule

/* rtl/cam_pkg.sv */
`include "cam_consts.svh"

package cam_pkg;

  // rgb565 pixel as it comes off the camera
  typedef struct packed {
    logic [4:0] r;
    logic [5:0] g;
    logic [4:0] b;
  } rgb565_t;

  // record carried down the pipeline next to each pixel
  typedef struct packed {
    rgb565_t                   pix;
    logic [`CAM_HCOUNT_W-1:0]  hcount;
    logic [`CAM_VCOUNT_W-1:0]  vcount;
    logic                      valid;   // single cycle pulse per pixel
  } pixel_rec_t;

  // converted colour space sample
  typedef struct packed {
    logic [7:0] y;
    logic [7:0] cr;
    logic [7:0] cb;
  } ycc_t;

  // lower bounds for the mask, inclusive
  typedef struct packed {
    logic [7:0] y;
    logic [7:0] cr;
    logic [7:0] cb;
  } cutoff_t;

  typedef logic [`CAM_CHUNK_W-1:0] chunk_t;  // pixel 0 in the low bits
  typedef logic [1:0]              display_mode_t;

endpackage

/* include/cam_consts.svh */
`ifndef CAM_CONSTS_SVH
`define CAM_CONSTS_SVH

// camera byte bus and rebuilt pixel
`define CAM_DATA_W        8
`define CAM_PIXEL_W       16
`define CAM_HCOUNT_W      11   // covers 1280 columns
`define CAM_VCOUNT_W      10   // covers 720 rows

// default frame geometry
`define CAM_FRAME_W       1280
`define CAM_FRAME_H       720

// output chunk packing
`define CAM_CHUNK_W       128
`define CAM_PIX_PER_CHUNK 8

// BT.601 coefficient magnitudes scaled by 256
`define CAM_Y_R           66
`define CAM_Y_G           129
`define CAM_Y_B           25
`define CAM_CB_R          38   // subtracted
`define CAM_CB_G          74   // subtracted
`define CAM_CB_B          112
`define CAM_CR_R          112
`define CAM_CR_G          94   // subtracted
`define CAM_CR_B          18   // subtracted

// display select codes
`define CAM_MODE_CAMERA   2'b00
`define CAM_MODE_MASK     2'b10
`define CAM_MODE_OVERLAY  2'b11

`define CAM_OVERLAY_COLOR 16'hF81F  // magenta in rgb565
`define CAM_MASK_ON       16'hFFFF
`define CAM_MASK_OFF      16'h0000

`endif
